//--- include/rob_consts.svh
/*
 * Sizing constants for the re-order buffer.
 * Included by the instruction package and by every RTL module that needs a
 * depth or a bus count.
 */

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Number of entries, must be a power of two
`define ROB_DEPTH 8

// Entry index width, log2 of the depth
`define ROB_TAG_WIDTH 3

// Result value width
`define ROB_DATA_WIDTH 32

// PC and branch target width
`define ROB_ADDR_WIDTH 32

// Destination register index width
`define ROB_RDEST_WIDTH 5

// Number of result buses
`define ROB_CDB_DEPTH 2

// Encoding width of the op enum
`define ROB_OP_WIDTH 2

`endif

//--- hdl/rob_instr_pkg.sv
/*
 * Instruction-side types shared by the re-order buffer and its testbench.
 * Import with rob_instr_pkg::* in the module header.
 */

`default_nettype none

`include "rob_consts.svh"

package rob_instr_pkg;

    // Operation class of an entry
    // Loads and stores retire like any other op here
    typedef enum logic [`ROB_OP_WIDTH-1:0] {
        ROB_OP_INT = 2'd0,
        ROB_OP_BR  = 2'd1,
        ROB_OP_LD  = 2'd2,
        ROB_OP_ST  = 2'd3
    } rob_op_t;

    // Entry index, returned to the dispatcher as the tag
    typedef logic [`ROB_TAG_WIDTH-1:0] rob_tag_t;

    // Result value carried on a CDB
    typedef logic [`ROB_DATA_WIDTH-1:0] rob_data_t;

    // Instruction PC or branch target
    typedef logic [`ROB_ADDR_WIDTH-1:0] rob_addr_t;

    // Architectural destination register
    typedef logic [`ROB_RDEST_WIDTH-1:0] rob_rdest_t;

endpackage

`default_nettype wire

//--- hdl/rob_ctrl_pkg.sv
/*
 * Types of the retire controller.
 * Only the retire FSM imports this package.
 */

`default_nettype none

package rob_ctrl_pkg;

    // RETIRE_RUN retires ready entries from the head in program order
    // RETIRE_FLUSH lasts one cycle after a redirecting retire and empties
    // the buffer at its end
    typedef enum logic {
        RETIRE_RUN   = 1'b0,
        RETIRE_FLUSH = 1'b1
    } retire_state_t;

endpackage

`default_nettype wire

//--- hdl/rob_ptr_counter.sv
/*
 * Head and tail pointers of the re-order buffer.
 * An extra wrap bit on each pointer tells a full buffer from an empty one.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_ptr_counter import rob_instr_pkg::*; (
    input  wire logic     clk,
    input  wire logic     n_rst,

    input  wire logic     i_alloc_en,
    input  wire logic     i_retire_adv,
    input  wire logic     i_flush,

    output rob_tag_t      o_tail_tag,
    output rob_tag_t      o_head_tag,
    output logic          o_full,
    output logic          o_empty
);

    logic [`ROB_TAG_WIDTH:0] head_q;
    logic [`ROB_TAG_WIDTH:0] tail_q;

    assign o_tail_tag = tail_q[`ROB_TAG_WIDTH-1:0];
    assign o_head_tag = head_q[`ROB_TAG_WIDTH-1:0];

    // Same index with opposite wrap bits means the tail has lapped the head
    assign o_full  = (tail_q[`ROB_TAG_WIDTH] != head_q[`ROB_TAG_WIDTH]) &&
                     (o_tail_tag == o_head_tag);
    assign o_empty = (tail_q == head_q);

    // A flush drops every entry, so it wins over a same-cycle allocation
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            tail_q <= '0;
        end else if (i_alloc_en) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            head_q <= '0;
        end else if (i_retire_adv) begin
            head_q <= head_q + 1'b1;
        end
    end

    // The retire FSM must gate allocation with the stall it reports
    assert property (@(posedge clk) disable iff (!n_rst)
        !(i_alloc_en && o_full))
        else $error("allocation while the buffer is full");

    // The head may only move over an allocated entry
    assert property (@(posedge clk) disable iff (!n_rst)
        !(i_retire_adv && o_empty))
        else $error("head advance while the buffer is empty");

endmodule

`default_nettype wire

//--- hdl/rob_entry_store.sv
/*
 * Entry storage of the re-order buffer.
 * Allocation fills the tail entry, the CDBs complete entries by tag, and a
 * single read port presents the head entry to the retire FSM.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_entry_store import rob_instr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       n_rst,

    // Allocation at the tail
    input  wire logic       i_alloc_en,
    input  wire rob_tag_t   i_alloc_tag,
    input  wire rob_op_t    i_enq_op,
    input  wire rob_addr_t  i_enq_pc,
    input  wire rob_rdest_t i_enq_rdest,

    // Result buses
    input  wire logic       i_cdb_en       [0:`ROB_CDB_DEPTH-1],
    input  wire rob_tag_t   i_cdb_tag      [0:`ROB_CDB_DEPTH-1],
    input  wire rob_data_t  i_cdb_data     [0:`ROB_CDB_DEPTH-1],
    input  wire rob_addr_t  i_cdb_addr     [0:`ROB_CDB_DEPTH-1],
    input  wire logic       i_cdb_redirect [0:`ROB_CDB_DEPTH-1],

    input  wire logic       i_flush,
    input  wire rob_tag_t   i_head_tag,

    // Head entry
    output logic            o_head_rdy,
    output logic            o_head_redirect,
    output rob_op_t         o_head_op,
    output rob_addr_t       o_head_pc,
    output rob_addr_t       o_head_addr,
    output rob_data_t       o_head_data,
    output rob_rdest_t      o_head_rdest
);

    logic                  entry_rdy_q      [0:`ROB_DEPTH-1];
    logic                  entry_redirect_q [0:`ROB_DEPTH-1];
    rob_op_t               entry_op_q       [0:`ROB_DEPTH-1];
    rob_addr_t             entry_pc_q       [0:`ROB_DEPTH-1];
    rob_addr_t             entry_addr_q     [0:`ROB_DEPTH-1];
    rob_data_t             entry_data_q     [0:`ROB_DEPTH-1];
    rob_rdest_t            entry_rdest_q    [0:`ROB_DEPTH-1];

    logic [`ROB_DEPTH-1:0] cdb_hit          [0:`ROB_CDB_DEPTH-1];
    logic [`ROB_DEPTH-1:0] alloc_sel;
    logic [`ROB_DEPTH-1:0] entry_hit;
    logic [`ROB_DEPTH-1:0] redirect_set;

    // One-hot entry select per CDB
    always_comb begin
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                cdb_hit[c][i] = i_cdb_en[c] && (i_cdb_tag[c] == rob_tag_t'(i));
            end
        end
    end

    // Fold the CDB hits into one completion and one redirect flag per entry
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            alloc_sel[i]    = i_alloc_en && (i_alloc_tag == rob_tag_t'(i));
            entry_hit[i]    = 1'b0;
            redirect_set[i] = 1'b0;
            for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
                entry_hit[i]    = entry_hit[i] | cdb_hit[c][i];
                redirect_set[i] = redirect_set[i] | (cdb_hit[c][i] & i_cdb_redirect[c]);
            end
        end
    end

    // Ready bits are the only state that must survive a flush as cleared
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (!n_rst || i_flush || alloc_sel[i]) begin
                entry_rdy_q[i] <= 1'b0;
            end else if (entry_hit[i]) begin
                entry_rdy_q[i] <= 1'b1;
            end
        end
    end

    // Allocation starts a fresh entry, completions can only add a redirect
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                entry_redirect_q[i] <= 1'b0;
                entry_op_q[i]       <= i_enq_op;
                entry_pc_q[i]       <= i_enq_pc;
                entry_rdest_q[i]    <= i_enq_rdest;
            end else begin
                entry_redirect_q[i] <= entry_redirect_q[i] | redirect_set[i];
            end
        end
    end

    // Result data and branch target from whichever bus completes the entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
                if (cdb_hit[c][i]) begin
                    entry_data_q[i] <= i_cdb_data[c];
                    entry_addr_q[i] <= i_cdb_addr[c];
                end
            end
        end
    end

    assign o_head_rdy      = entry_rdy_q[i_head_tag];
    assign o_head_redirect = entry_redirect_q[i_head_tag];
    assign o_head_op       = entry_op_q[i_head_tag];
    assign o_head_pc       = entry_pc_q[i_head_tag];
    assign o_head_addr     = entry_addr_q[i_head_tag];
    assign o_head_data     = entry_data_q[i_head_tag];
    assign o_head_rdest    = entry_rdest_q[i_head_tag];

    // Execution units never broadcast the same tag twice in one cycle
    for (genvar a = 0; a < `ROB_CDB_DEPTH; a++) begin : g_cdb_a
        for (genvar b = a + 1; b < `ROB_CDB_DEPTH; b++) begin : g_cdb_b
            assert property (@(posedge clk) disable iff (!n_rst)
                !(i_cdb_en[a] && i_cdb_en[b] && (i_cdb_tag[a] == i_cdb_tag[b])))
                else $error("two CDBs carry the same tag");
        end
    end

endmodule

`default_nettype wire

//--- hdl/rob_retire_fsm.sv
/*
 * Retire controller of the re-order buffer.
 * Gates allocation, retires the head in order, and runs the one-cycle
 * flush that follows a redirecting retire.
 */

`timescale 1ns/1ps
`default_nettype none

module rob_retire_fsm import rob_instr_pkg::*, rob_ctrl_pkg::*; (
    input  wire logic       clk,
    input  wire logic       n_rst,

    input  wire logic       i_enq_en,
    input  wire logic       i_full,
    input  wire logic       i_empty,
    input  wire rob_tag_t   i_head_tag,

    input  wire logic       i_head_rdy,
    input  wire logic       i_head_redirect,
    input  wire rob_op_t    i_head_op,
    input  wire rob_addr_t  i_head_pc,
    input  wire rob_addr_t  i_head_addr,
    input  wire rob_data_t  i_head_data,
    input  wire rob_rdest_t i_head_rdest,

    output logic            o_alloc_en,
    output logic            o_retire_adv,
    output logic            o_flush,
    output logic            o_rob_stall,

    output logic            o_retire_en,
    output rob_tag_t        o_retire_tag,
    output rob_data_t       o_retire_data,
    output rob_rdest_t      o_retire_rdest,
    output logic            o_redirect,
    output rob_addr_t       o_redirect_addr
);

    retire_state_t state_q;
    retire_state_t state_d;
    logic          retire_redirect;
    rob_addr_t     redirect_sel;

    assign o_flush      = (state_q == RETIRE_FLUSH);
    assign o_rob_stall  = i_full || o_flush;
    assign o_alloc_en   = i_enq_en && !o_rob_stall;
    assign o_retire_adv = (state_q == RETIRE_RUN) && i_head_rdy && !i_empty;

    assign retire_redirect = o_retire_adv && i_head_redirect;

    // Branches resume at their resolved target, anything else replays from its PC
    assign redirect_sel = (i_head_op == ROB_OP_BR) ? i_head_addr : i_head_pc;

    always_comb begin
        case (state_q)
            RETIRE_RUN:   state_d = retire_redirect ? RETIRE_FLUSH : RETIRE_RUN;
            RETIRE_FLUSH: state_d = RETIRE_RUN;
            default:      state_d = RETIRE_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state_q     <= RETIRE_RUN;
            o_retire_en <= 1'b0;
            o_redirect  <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_retire_en <= o_retire_adv;
            o_redirect  <= retire_redirect;
        end
    end

    // Retire payload is captured only when the head actually leaves
    always_ff @(posedge clk) begin
        if (o_retire_adv) begin
            o_retire_tag    <= i_head_tag;
            o_retire_data   <= i_head_data;
            o_retire_rdest  <= i_head_rdest;
            o_redirect_addr <= redirect_sel;
        end
    end

    // The flush that follows a redirect empties the buffer, so a second
    // redirect cannot come straight after
    assert property (@(posedge clk) disable iff (!n_rst)
        o_redirect |=> (!o_redirect && i_empty))
        else $error("redirect not followed by a single flush to an empty buffer");

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
/*
 * Re-order buffer top level.
 * Connects the pointer counter, the entry store and the retire FSM.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_top import rob_instr_pkg::*; (
    input  wire logic       clk,
    input  wire logic       n_rst,

    // Dispatcher enqueue
    input  wire logic       i_enq_en,
    input  wire rob_op_t    i_enq_op,
    input  wire rob_addr_t  i_enq_pc,
    input  wire rob_rdest_t i_enq_rdest,
    output logic            o_rob_stall,
    output rob_tag_t        o_enq_tag,

    // Result buses
    input  wire logic       i_cdb_en       [0:`ROB_CDB_DEPTH-1],
    input  wire rob_tag_t   i_cdb_tag      [0:`ROB_CDB_DEPTH-1],
    input  wire rob_data_t  i_cdb_data     [0:`ROB_CDB_DEPTH-1],
    input  wire rob_addr_t  i_cdb_addr     [0:`ROB_CDB_DEPTH-1],
    input  wire logic       i_cdb_redirect [0:`ROB_CDB_DEPTH-1],

    // Retire and redirect
    output logic            o_retire_en,
    output rob_tag_t        o_retire_tag,
    output rob_data_t       o_retire_data,
    output rob_rdest_t      o_retire_rdest,
    output logic            o_redirect,
    output rob_addr_t       o_redirect_addr
);

    logic       alloc_en;
    logic       retire_adv;
    logic       flush;
    logic       full;
    logic       empty;
    rob_tag_t   head_tag;
    logic       head_rdy;
    logic       head_redirect;
    rob_op_t    head_op;
    rob_addr_t  head_pc;
    rob_addr_t  head_addr;
    rob_data_t  head_data;
    rob_rdest_t head_rdest;

    // The tail index is the tag handed back to the dispatcher
    rob_ptr_counter u_ptr (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_alloc_en   (alloc_en),
        .i_retire_adv (retire_adv),
        .i_flush      (flush),
        .o_tail_tag   (o_enq_tag),
        .o_head_tag   (head_tag),
        .o_full       (full),
        .o_empty      (empty)
    );

    rob_entry_store u_store (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_alloc_en      (alloc_en),
        .i_alloc_tag     (o_enq_tag),
        .i_enq_op        (i_enq_op),
        .i_enq_pc        (i_enq_pc),
        .i_enq_rdest     (i_enq_rdest),
        .i_cdb_en        (i_cdb_en),
        .i_cdb_tag       (i_cdb_tag),
        .i_cdb_data      (i_cdb_data),
        .i_cdb_addr      (i_cdb_addr),
        .i_cdb_redirect  (i_cdb_redirect),
        .i_flush         (flush),
        .i_head_tag      (head_tag),
        .o_head_rdy      (head_rdy),
        .o_head_redirect (head_redirect),
        .o_head_op       (head_op),
        .o_head_pc       (head_pc),
        .o_head_addr     (head_addr),
        .o_head_data     (head_data),
        .o_head_rdest    (head_rdest)
    );

    rob_retire_fsm u_fsm (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_enq_en        (i_enq_en),
        .i_full          (full),
        .i_empty         (empty),
        .i_head_tag      (head_tag),
        .i_head_rdy      (head_rdy),
        .i_head_redirect (head_redirect),
        .i_head_op       (head_op),
        .i_head_pc       (head_pc),
        .i_head_addr     (head_addr),
        .i_head_data     (head_data),
        .i_head_rdest    (head_rdest),
        .o_alloc_en      (alloc_en),
        .o_retire_adv    (retire_adv),
        .o_flush         (flush),
        .o_rob_stall     (o_rob_stall),
        .o_retire_en     (o_retire_en),
        .o_retire_tag    (o_retire_tag),
        .o_retire_data   (o_retire_data),
        .o_retire_rdest  (o_retire_rdest),
        .o_redirect      (o_redirect),
        .o_redirect_addr (o_redirect_addr)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rob.sv
/*
 * Self-checking testbench for the re-order buffer.
 * Random enqueues and out-of-order completions are checked against a queue
 * model that retires in program order, then back-pressure and redirects.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module tb_rob import rob_instr_pkg::*; ();

    logic       clk;
    logic       n_rst;
    logic       enq_en;
    rob_op_t    enq_op;
    rob_addr_t  enq_pc;
    rob_rdest_t enq_rdest;
    logic       rob_stall;
    rob_tag_t   enq_tag;
    logic       cdb_en       [0:`ROB_CDB_DEPTH-1];
    rob_tag_t   cdb_tag      [0:`ROB_CDB_DEPTH-1];
    rob_data_t  cdb_data     [0:`ROB_CDB_DEPTH-1];
    rob_addr_t  cdb_addr     [0:`ROB_CDB_DEPTH-1];
    logic       cdb_redirect [0:`ROB_CDB_DEPTH-1];
    logic       retire_en;
    rob_tag_t   retire_tag;
    rob_data_t  retire_data;
    rob_rdest_t retire_rdest;
    logic       redirect;
    rob_addr_t  redirect_addr;

    // Values to drive at the next rising edge
    logic       nx_enq_en;
    rob_op_t    nx_op;
    rob_addr_t  nx_pc;
    rob_rdest_t nx_rdest;
    logic       nx_cdb_en       [0:`ROB_CDB_DEPTH-1];
    rob_tag_t   nx_cdb_tag      [0:`ROB_CDB_DEPTH-1];
    rob_data_t  nx_cdb_data     [0:`ROB_CDB_DEPTH-1];
    rob_addr_t  nx_cdb_addr     [0:`ROB_CDB_DEPTH-1];
    logic       nx_cdb_redirect [0:`ROB_CDB_DEPTH-1];

    // Reference model, program order in order_q and entry fields by tag
    rob_tag_t   order_q[$];
    rob_op_t    m_op    [0:`ROB_DEPTH-1];
    rob_addr_t  m_pc    [0:`ROB_DEPTH-1];
    rob_rdest_t m_rdest [0:`ROB_DEPTH-1];
    logic       m_done  [0:`ROB_DEPTH-1];
    rob_data_t  m_data  [0:`ROB_DEPTH-1];
    rob_addr_t  m_addr  [0:`ROB_DEPTH-1];
    logic       m_redir [0:`ROB_DEPTH-1];
    rob_tag_t   m_tail;

    integer     seed;
    int         errors;
    int         err_base;
    int         tests_run;
    int         tests_failed;
    int         retires;
    int         redirects;
    int         n;
    rob_tag_t   tag;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    rob_top u_dut (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_enq_en        (enq_en),
        .i_enq_op        (enq_op),
        .i_enq_pc        (enq_pc),
        .i_enq_rdest     (enq_rdest),
        .o_rob_stall     (rob_stall),
        .o_enq_tag       (enq_tag),
        .i_cdb_en        (cdb_en),
        .i_cdb_tag       (cdb_tag),
        .i_cdb_data      (cdb_data),
        .i_cdb_addr      (cdb_addr),
        .i_cdb_redirect  (cdb_redirect),
        .o_retire_en     (retire_en),
        .o_retire_tag    (retire_tag),
        .o_retire_data   (retire_data),
        .o_retire_rdest  (retire_rdest),
        .o_redirect      (redirect),
        .o_redirect_addr (redirect_addr)
    );

    function automatic int rand_below(input int limit);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % limit;
    endfunction

    function automatic rob_op_t pick_plain_op();
        case (rand_below(3))
            0:       return ROB_OP_INT;
            1:       return ROB_OP_LD;
            default: return ROB_OP_ST;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while %s", what);
        errors++;
    endtask

    task automatic check_retire(input rob_tag_t exp_tag, input rob_data_t exp_data,
                                input rob_rdest_t exp_rdest);
        if (retire_tag !== exp_tag || retire_data !== exp_data || retire_rdest !== exp_rdest) begin
            report_error($sformatf("retire tag %0d data %h rdest %0d, expected %0d %h %0d",
                retire_tag, retire_data, retire_rdest, exp_tag, exp_data, exp_rdest));
        end
    endtask

    task automatic check_redirect(input logic exp_en, input rob_addr_t exp_addr);
        if (redirect !== exp_en) begin
            report_error($sformatf("redirect is %b, expected %b", redirect, exp_en));
        end else if (exp_en && redirect_addr !== exp_addr) begin
            report_error($sformatf("redirect address %h, expected %h", redirect_addr, exp_addr));
        end
    endtask

    task automatic check_stall(input logic exp_stall);
        if (rob_stall !== exp_stall) begin
            report_error($sformatf("stall is %b, expected %b", rob_stall, exp_stall));
        end
    endtask

    task automatic check_enq_tag(input rob_tag_t exp_tag);
        if (enq_tag !== exp_tag) begin
            report_error($sformatf("enqueue tag %0d, expected %0d", enq_tag, exp_tag));
        end
    endtask

    // Runs at the falling edge, where every DUT output is settled
    task automatic observe();
        rob_tag_t head;
        logic     flush_now;
        flush_now = 1'b0;
        if (retire_en === 1'b1) begin
            if (order_q.size() == 0) begin
                report_error("retire with no pending entry");
            end else begin
                head = order_q.pop_front();
                if (!m_done[head]) begin
                    report_error("retired an entry that never completed");
                end
                check_retire(head, m_data[head], m_rdest[head]);
                check_redirect(m_redir[head],
                    (m_op[head] == ROB_OP_BR) ? m_addr[head] : m_pc[head]);
                flush_now = m_redir[head];
                retires++;
                if (flush_now) begin
                    redirects++;
                end
            end
        end else begin
            check_redirect(1'b0, '0);
        end
        check_stall(flush_now || (order_q.size() == `ROB_DEPTH));

        // Completions on the buses take effect at the coming edge
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            if (cdb_en[c]) begin
                m_done[cdb_tag[c]]  = 1'b1;
                m_data[cdb_tag[c]]  = cdb_data[c];
                m_addr[cdb_tag[c]]  = cdb_addr[c];
                m_redir[cdb_tag[c]] = m_redir[cdb_tag[c]] | cdb_redirect[c];
            end
        end

        if (enq_en && !rob_stall) begin
            check_enq_tag(m_tail);
            order_q.push_back(enq_tag);
            m_op[enq_tag]    = enq_op;
            m_pc[enq_tag]    = enq_pc;
            m_rdest[enq_tag] = enq_rdest;
            m_done[enq_tag]  = 1'b0;
            m_redir[enq_tag] = 1'b0;
            m_tail           = m_tail + 1'b1;
        end

        // The flush cycle empties the buffer and restarts allocation at tag 0
        if (flush_now) begin
            order_q.delete();
            m_tail = '0;
        end
    endtask

    task automatic clear_next();
        nx_enq_en = 1'b0;
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            nx_cdb_en[c]       = 1'b0;
            nx_cdb_redirect[c] = 1'b0;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        enq_en    <= nx_enq_en;
        enq_op    <= nx_op;
        enq_pc    <= nx_pc;
        enq_rdest <= nx_rdest;
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            cdb_en[c]       <= nx_cdb_en[c];
            cdb_tag[c]      <= nx_cdb_tag[c];
            cdb_data[c]     <= nx_cdb_data[c];
            cdb_addr[c]     <= nx_cdb_addr[c];
            cdb_redirect[c] <= nx_cdb_redirect[c];
        end
        clear_next();
        @(negedge clk);
        observe();
    endtask

    task automatic plan_enqueue(input rob_op_t op);
        nx_enq_en = 1'b1;
        nx_op     = op;
        nx_pc     = rob_addr_t'($random(seed)) & ~rob_addr_t'(3);
        nx_rdest  = rob_rdest_t'(rand_below(32));
    endtask

    task automatic plan_complete(input int bus, input rob_tag_t ctag, input logic redir);
        nx_cdb_en[bus]       = 1'b1;
        nx_cdb_tag[bus]      = ctag;
        nx_cdb_data[bus]     = rob_data_t'($random(seed));
        nx_cdb_addr[bus]     = rob_addr_t'($random(seed)) & ~rob_addr_t'(3);
        nx_cdb_redirect[bus] = redir;
    endtask

    // Random pending entry that no bus has claimed yet
    task automatic pick_pending(output logic found, output rob_tag_t ptag);
        rob_tag_t cand[$];
        logic     taken;
        foreach (order_q[i]) begin
            taken = m_done[order_q[i]];
            for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
                if (nx_cdb_en[c] && nx_cdb_tag[c] == order_q[i]) begin
                    taken = 1'b1;
                end
            end
            if (!taken) begin
                cand.push_back(order_q[i]);
            end
        end
        found = (cand.size() != 0);
        ptag  = found ? cand[rand_below(cand.size())] : rob_tag_t'(0);
    endtask

    task automatic random_completions();
        logic     found;
        rob_tag_t ptag;
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            if (rand_below(2) == 0) begin
                pick_pending(found, ptag);
                if (found) begin
                    plan_complete(c, ptag, 1'b0);
                end
            end
        end
    endtask

    task automatic drain(input int limit);
        int k;
        k = 0;
        while (order_q.size() != 0 && k < limit) begin
            random_completions();
            tick();
            k++;
        end
        if (order_q.size() != 0) begin
            timed_out("draining the buffer");
        end
    endtask

    task automatic wait_retires(input int target, input int limit);
        int k;
        k = 0;
        while (retires < target && k < limit) begin
            tick();
            k++;
        end
        if (retires < target) begin
            timed_out("waiting for a retire");
        end
    endtask

    task automatic wait_redirects(input int target, input int limit);
        int k;
        k = 0;
        while (redirects < target && k < limit) begin
            tick();
            k++;
        end
        if (redirects < target) begin
            timed_out("waiting for a redirect");
        end
    endtask

    task automatic start_test();
        err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_base) begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end else begin
            $display("Test %0d %s: PASS", tests_run, name);
        end
    endtask

    initial begin
        seed         = 6148;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        retires      = 0;
        redirects    = 0;
        m_tail       = '0;
        n_rst        = 1'b0;
        enq_en       = 1'b0;
        enq_op       = ROB_OP_INT;
        enq_pc       = '0;
        enq_rdest    = '0;
        nx_op        = ROB_OP_INT;
        nx_pc        = '0;
        nx_rdest     = '0;
        for (int c = 0; c < `ROB_CDB_DEPTH; c++) begin
            cdb_en[c]       = 1'b0;
            cdb_tag[c]      = '0;
            cdb_data[c]     = '0;
            cdb_addr[c]     = '0;
            cdb_redirect[c] = 1'b0;
            nx_cdb_tag[c]   = '0;
            nx_cdb_data[c]  = '0;
            nx_cdb_addr[c]  = '0;
        end
        clear_next();
        repeat (10) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);

        start_test();
        if (retire_en !== 1'b0) begin
            report_error("retire active after reset");
        end
        check_redirect(1'b0, '0);
        check_stall(1'b0);
        end_test("reset state");

        start_test();
        for (int i = 0; i < 300; i++) begin
            if (rand_below(3) != 0) begin
                plan_enqueue(pick_plain_op());
            end
            random_completions();
            tick();
        end
        drain(200);
        end_test("random in-order retire");

        // Fill without completions, then one enqueue against the stall
        start_test();
        n = 0;
        while (order_q.size() < `ROB_DEPTH && n < 50) begin
            plan_enqueue(ROB_OP_INT);
            tick();
            n++;
        end
        if (order_q.size() < `ROB_DEPTH) begin
            timed_out("filling the buffer");
        end
        plan_enqueue(ROB_OP_LD);
        tick();
        check_stall(1'b1);
        if (order_q.size() != `ROB_DEPTH) begin
            report_error("enqueue accepted while full");
        end
        plan_complete(0, order_q[0], 1'b0);
        tick();
        wait_retires(retires + 1, 20);
        check_stall(1'b0);
        drain(200);
        end_test("back-pressure");

        // Younger entries complete first and must vanish in the flush
        start_test();
        plan_enqueue(ROB_OP_INT);
        tick();
        plan_enqueue(ROB_OP_BR);
        tick();
        plan_enqueue(ROB_OP_INT);
        tick();
        plan_enqueue(ROB_OP_LD);
        tick();
        plan_complete(0, order_q[2], 1'b0);
        plan_complete(1, order_q[3], 1'b0);
        tick();
        plan_complete(0, order_q[0], 1'b0);
        plan_complete(1, order_q[1], 1'b1);
        tick();
        wait_redirects(redirects + 1, 20);
        for (int i = 0; i < 6; i++) begin
            tick();
            if (retire_en !== 1'b0) begin
                report_error("retire after the flush");
            end
        end
        plan_enqueue(ROB_OP_INT);
        tick();
        check_enq_tag('0);
        drain(50);
        end_test("branch redirect");

        start_test();
        plan_enqueue(ROB_OP_ST);
        tick();
        tag = order_q[0];
        plan_complete(1, tag, 1'b1);
        tick();
        wait_redirects(redirects + 1, 20);
        repeat (3) tick();
        end_test("non-branch redirect");

        $display("Tests run %0d, failing %0d, errors %0d, retires %0d",
            tests_run, tests_failed, errors, retires);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/rob_instr_pkg.sv
hdl/rob_ctrl_pkg.sv
hdl/rob_ptr_counter.sv
hdl/rob_entry_store.sv
hdl/rob_retire_fsm.sv
hdl/rob_top.sv
testbench/tb_rob.sv

//--- Bender.yml
package:
  name: rob

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/rob_instr_pkg.sv
      - hdl/rob_ctrl_pkg.sv
      - hdl/rob_ptr_counter.sv
      - hdl/rob_entry_store.sv
      - hdl/rob_retire_fsm.sv
      - hdl/rob_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_rob.sv
